// File: biquad_iir.sv
// ----------------------------------------------------------
// Direct-form-I biquad, one sample at a time
// b0 product is issued in the input transfer cycle
// New coefficients load only while idle, between samples
// Output saturates to 18 bits, err_overflow marks it
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module biquad_iir import lpf_pkg::*; (
    input  wire                         reset,
    input  wire                         clk,
    input  wire                         coef_valid,
    input  wire [5*SAMPLE_W-1:0]        coefs,
    input  wire                         sample_in_valid,
    output logic                        sample_in_ready,
    input  wire signed [SAMPLE_W-1:0]   sample_in,
    mult_if.requester                   mult,
    output logic                        sample_out_valid,
    input  wire                         sample_out_ready,
    output logic signed [SAMPLE_W-1:0]  sample_out,
    output logic                        err_overflow
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RUN  = 2'd1;
    localparam logic [1:0] ST_OUT  = 2'd2;

    localparam logic signed [SAMPLE_W-1:0] SAT_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
    localparam logic signed [SAMPLE_W-1:0] SAT_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

    logic [1:0]                 state;
    logic [2:0]                 iss_cnt;
    logic [2:0]                 ret_cnt;
    logic                       coef_pend;
    logic                       in_xfer;
    logic                       out_xfer;
    logic                       last_ret;
    logic                       sat;
    logic signed [SAMPLE_W-1:0] k_b0, k_b1, k_b2, k_a1, k_a2;
    logic signed [SAMPLE_W-1:0] x0, x1, x2, y1, y2;
    logic signed [SAMPLE_W-1:0] sat_val;
    logic signed [ACC_W-1:0]    acc;
    logic signed [ACC_W-1:0]    acc_next;
    logic signed [ACC_W-1:0]    acc_shr;

    // Hold off input while a coefficient load is due
    assign sample_in_ready = (state == ST_IDLE) && !coef_pend && !coef_valid;
    assign in_xfer         = sample_in_valid && sample_in_ready;
    assign out_xfer        = sample_out_valid && sample_out_ready;
    assign last_ret        = mult.p_valid && (ret_cnt == 3'd4);
    assign mult.req        = in_xfer || ((state == ST_RUN) && (iss_cnt < 3'd5));

    // Operand pair per issue slot
    always_comb begin
        case (iss_cnt)
            3'd0: begin
                mult.a = k_b0;
                mult.b = (state == ST_IDLE) ? sample_in : x0;
            end
            3'd1: begin mult.a = k_b1; mult.b = x1; end
            3'd2: begin mult.a = k_b2; mult.b = x2; end
            3'd3: begin mult.a = k_a1; mult.b = y1; end
            default: begin mult.a = k_a2; mult.b = y2; end
        endcase
    end

    // a2 term is the fifth return and is subtracted
    always_comb begin
        acc_next = (ret_cnt == 3'd4) ? acc - mult.p : acc + mult.p;
        acc_shr  = acc_next >>> FRAC_W;
        // Bits above the sample must all match the sign
        sat      = !((&acc_shr[ACC_W-1:SAMPLE_W-1]) || !(|acc_shr[ACC_W-1:SAMPLE_W-1]));
        sat_val  = sat ? (acc_shr[ACC_W-1] ? SAT_MIN : SAT_MAX) : acc_shr[SAMPLE_W-1:0];
    end

    // ------------------------------------------------------
    // Control and history
    // ------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state            <= ST_IDLE;
            iss_cnt          <= 3'd0;
            ret_cnt          <= 3'd0;
            coef_pend        <= 1'b0;
            sample_out_valid <= 1'b0;
            err_overflow     <= 1'b0;
            x1               <= '0;
            x2               <= '0;
            y1               <= '0;
            y2               <= '0;
        end else begin
            // Calculator holds coefs, so only a flag is kept
            if (state == ST_IDLE) begin
                coef_pend <= 1'b0;
            end else if (coef_valid) begin
                coef_pend <= 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (in_xfer) begin
                        state   <= ST_RUN;
                        iss_cnt <= {2'b00, mult.gnt};
                        ret_cnt <= 3'd0;
                    end
                end
                ST_RUN: begin
                    if (mult.req && mult.gnt) iss_cnt <= iss_cnt + 3'd1;
                    if (mult.p_valid) ret_cnt <= ret_cnt + 3'd1;
                    if (last_ret) begin
                        state            <= ST_OUT;
                        iss_cnt          <= 3'd0;
                        sample_out_valid <= 1'b1;
                        err_overflow     <= sat;
                    end
                end
                default: begin
                    // Shift histories once the output is taken
                    if (out_xfer) begin
                        state            <= ST_IDLE;
                        sample_out_valid <= 1'b0;
                        err_overflow     <= 1'b0;
                        x1               <= x0;
                        x2               <= x1;
                        y1               <= sample_out;
                        y2               <= y1;
                    end
                end
            endcase
        end
    end

    // Coefficients, current input and accumulator
    always_ff @(posedge reset) begin
        if ((state == ST_IDLE) && (coef_valid || coef_pend)) begin
            k_b0 <= coefs[4*SAMPLE_W +: SAMPLE_W];
            k_b1 <= coefs[3*SAMPLE_W +: SAMPLE_W];
            k_b2 <= coefs[2*SAMPLE_W +: SAMPLE_W];
            k_a1 <= coefs[SAMPLE_W +: SAMPLE_W];
            k_a2 <= coefs[0 +: SAMPLE_W];
        end
        if (in_xfer) begin
            x0  <= sample_in;
            acc <= '0;
        end else if (mult.p_valid) begin
            acc <= acc_next;
        end
        if (last_ret) begin
            sample_out <= sat_val;
        end
    end

endmodule

`default_nettype wire

// File: lpf_coef_calc.sv
// ----------------------------------------------------------
// Biquad coefficient calculator on the shared multiplier
// Two products per pass, w2 then alpha, issued back to back
// Coefs hold their value until the next coef_valid pulse
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lpf_coef_calc import lpf_pkg::*; (
    input  wire                         reset,
    input  wire                         clk,
    input  wire                         stale,
    input  wire signed [SAMPLE_W-1:0]   omega0,
    input  wire signed [SAMPLE_W-1:0]   inv_2q,
    output logic                        calc_start,
    mult_if.requester                   mult,
    output logic                        coef_valid,
    output logic [5*SAMPLE_W-1:0]       coefs
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_W2    = 2'd1;
    localparam logic [1:0] ST_ALPHA = 2'd2;
    localparam logic [1:0] ST_WAIT  = 2'd3;

    logic [1:0]                 state;
    logic                       w2_seen;
    logic signed [SAMPLE_W-1:0] omega0_r;
    logic signed [SAMPLE_W-1:0] inv_2q_r;
    logic signed [SAMPLE_W-1:0] w2_r;
    logic signed [SAMPLE_W-1:0] alpha;
    logic signed [SAMPLE_W-1:0] c_b0;
    logic signed [SAMPLE_W-1:0] c_b1;
    logic signed [SAMPLE_W-1:0] c_a1;
    logic signed [SAMPLE_W-1:0] c_a2;

    assign calc_start = (state == ST_IDLE) && stale;

    // Operands for the two issue states
    assign mult.req = (state == ST_W2) || (state == ST_ALPHA);
    assign mult.a   = omega0_r;
    assign mult.b   = (state == ST_W2) ? omega0_r : inv_2q_r;

    // Second return is alpha, used straight off the bus
    assign alpha = mult.p[FRAC_W +: SAMPLE_W];
    assign c_b0  = w2_r >>> 2;
    assign c_b1  = w2_r >>> 1;
    assign c_a1  = (ONE_Q <<< 1) - w2_r;
    assign c_a2  = ONE_Q - (alpha <<< 1);

    // ------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state      <= ST_IDLE;
            w2_seen    <= 1'b0;
            coef_valid <= 1'b0;
        end else begin
            coef_valid <= 1'b0;
            case (state)
                ST_IDLE:  if (calc_start) state <= ST_W2;
                ST_W2:    if (mult.gnt) state <= ST_ALPHA;
                ST_ALPHA: if (mult.gnt) state <= ST_WAIT;
                default:  if (mult.p_valid && w2_seen) state <= ST_IDLE;
            endcase
            // Products come back in issue order
            if (mult.p_valid) begin
                w2_seen    <= !w2_seen;
                coef_valid <= w2_seen;
            end
        end
    end

    // Parameter snapshot and results
    always_ff @(posedge reset) begin
        if (calc_start) begin
            omega0_r <= omega0;
            inv_2q_r <= inv_2q;
        end
        if (mult.p_valid && !w2_seen) begin
            w2_r <= mult.p[FRAC_W +: SAMPLE_W];
        end
        // Packed b0 at the top, a2 at the bottom
        if (mult.p_valid && w2_seen) begin
            coefs <= {c_b0, c_b1, c_b0, c_a1, c_a2};
        end
    end

endmodule

`default_nettype wire

// File: lpf_pkg.sv
// ----------------------------------------------------------
// Shared widths and constants for the biquad low-pass voice
// Samples and coefficients are signed Q2.16 in 18 bits
// Products are full 36-bit, accumulation is 40-bit
// ----------------------------------------------------------
`default_nettype none

package lpf_pkg;

    // Datapath widths
    localparam int SAMPLE_W = 18;
    localparam int PROD_W   = 36;
    localparam int ACC_W    = 40;
    // Q2.16 fraction bits
    localparam int FRAC_W   = 16;

    // Decoded MIDI command
    localparam int MIDI_CMD_W = 3;
    // Control change, low bits of status nibble 0xB
    localparam logic [MIDI_CMD_W-1:0] MIDI_CMD_CC = 3'd3;

    // Filter parameters after reset
    localparam logic signed [SAMPLE_W-1:0] OMEGA0_RESET = 18'sh01999;
    localparam logic signed [SAMPLE_W-1:0] INV_2Q_RESET = 18'sh08000;

    // 1.0 in Q2.16
    localparam logic signed [SAMPLE_W-1:0] ONE_Q = 18'sh10000;

    // Multiplier requester tags
    localparam logic REQ_IIR  = 1'b0;
    localparam logic REQ_COEF = 1'b1;

endpackage

`default_nettype wire

// File: lpf_properties.sv
// ----------------------------------------------------------
// Bound checks for the shared multiplier and output handshake
// Unused inputs of a binding are tied low
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lpf_properties (
    input wire reset,
    input wire clk,
    input wire req_iir,
    input wire req_coef,
    input wire gnt_iir,
    input wire gnt_coef,
    input wire pv_iir,
    input wire pv_coef,
    input wire out_valid,
    input wire out_ready,
    input wire [17:0] out_data
);

    // Loser of a tie is served on the next cycle
    assert property (@(posedge reset) disable iff (clk) req_iir && !gnt_iir |=> gnt_iir)
        else $error("filter request not served after losing a tie");
    assert property (@(posedge reset) disable iff (clk) req_coef && !gnt_coef |=> gnt_coef)
        else $error("calculator request not served after losing a tie");

    // Product two cycles after its grant
    assert property (@(posedge reset) disable iff (clk) gnt_iir |-> ##2 pv_iir)
        else $error("filter product missing");
    assert property (@(posedge reset) disable iff (clk) gnt_coef |-> ##2 pv_coef)
        else $error("calculator product missing");
    assert property (@(posedge reset) disable iff (clk) pv_iir |-> $past(gnt_iir, 2))
        else $error("filter product without grant");
    assert property (@(posedge reset) disable iff (clk) pv_coef |-> $past(gnt_coef, 2))
        else $error("calculator product without grant");

    // Output holds under back-pressure
    assert property (@(posedge reset) disable iff (clk)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("output changed while stalled");

endmodule

bind shared_mult_arbiter lpf_properties arb_props_i (
    .reset (reset), .clk (clk),
    .req_iir (iir.req), .req_coef (coef.req),
    .gnt_iir (iir.gnt), .gnt_coef (coef.gnt),
    .pv_iir (iir.p_valid), .pv_coef (coef.p_valid),
    .out_valid (1'b0), .out_ready (1'b0), .out_data (18'd0)
);

bind biquad_iir lpf_properties out_props_i (
    .reset (reset), .clk (clk),
    .req_iir (1'b0), .req_coef (1'b0),
    .gnt_iir (1'b0), .gnt_coef (1'b0), .pv_iir (1'b0), .pv_coef (1'b0),
    .out_valid (sample_out_valid), .out_ready (sample_out_ready), .out_data (sample_out)
);

`default_nettype wire

// File: lpf_tb.sv
// ----------------------------------------------------------
// Testbench for the biquad low-pass voice
// Port reset is the clock, port clk the async high reset
// One sample in flight at a time, checked against a model
// Samples wait 12 cycles after any parameter change
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lpf_tb import lpf_pkg::*;;

    // Sample count and per-item worst cases for the run limit
    localparam int N_SAMPLES   = 230;
    localparam int SAMPLE_WC   = 16;
    localparam int N_SETTLES   = 12;
    localparam int SETTLE_WC   = 14;
    localparam int CYCLE_LIMIT = 2 * (N_SAMPLES * SAMPLE_WC + N_SETTLES * SETTLE_WC + 20);

    logic                       reset;
    logic                       clk;
    logic                       midi_valid;
    logic [MIDI_CMD_W-1:0]      midi_cmd;
    logic [3:0]                 midi_ch;
    logic [6:0]                 midi_data0;
    logic [6:0]                 midi_data1;
    logic                       sample_in_valid;
    wire                        sample_in_ready;
    logic signed [SAMPLE_W-1:0] sample_in;
    wire                        sample_out_valid;
    logic                       sample_out_ready;
    wire signed [SAMPLE_W-1:0]  sample_out;
    wire                        err_overflow;

    logic [31:0] lcg_state;
    int          cycles;
    int          errors;
    int          checks;
    int          tests;
    int          test_errors;
    int          sent;
    int          xfers;
    int          sat_seen;

    // Reference model state
    logic signed [SAMPLE_W-1:0] m_omega0, m_inv_2q;
    logic signed [SAMPLE_W-1:0] m_b0, m_b1, m_b2, m_a1, m_a2;
    logic signed [SAMPLE_W-1:0] m_x1, m_x2, m_y1, m_y2;

    lpf_voice_top lpf_voice_top_i (
        .reset            (reset),
        .clk              (clk),
        .midi_valid       (midi_valid),
        .midi_cmd         (midi_cmd),
        .midi_ch          (midi_ch),
        .midi_data0       (midi_data0),
        .midi_data1       (midi_data1),
        .sample_in_valid  (sample_in_valid),
        .sample_in_ready  (sample_in_ready),
        .sample_in        (sample_in),
        .sample_out_valid (sample_out_valid),
        .sample_out_ready (sample_out_ready),
        .sample_out       (sample_out),
        .err_overflow     (err_overflow)
    );

    initial begin
        reset = 1'b0;
        forever #50 reset = ~reset;
    end

    // Run limit and output transfer count
    always @(posedge reset) begin
        cycles <= cycles + 1;
        if (!clk && sample_out_valid && sample_out_ready) begin
            xfers <= xfers + 1;
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the DUT stopped answering after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic signed [SAMPLE_W-1:0] rand_sample();
        logic [31:0] r;
        r = lcg_next();
        return r[31:14];
    endfunction

    task automatic check(input string name, input int expected, input int actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------
    // Model of the coefficient and filter arithmetic
    // ------------------------------------------------------
    task automatic model_coefs();
        logic signed [PROD_W-1:0] pw;
        logic signed [PROD_W-1:0] pa;
        logic signed [SAMPLE_W-1:0] w2;
        logic signed [SAMPLE_W-1:0] alpha;
        int t;
        pw = m_omega0 * m_omega0;
        pa = m_omega0 * m_inv_2q;
        pw = pw >>> FRAC_W;
        pa = pa >>> FRAC_W;
        w2    = pw[SAMPLE_W-1:0];
        alpha = pa[SAMPLE_W-1:0];
        m_b0 = w2 >>> 2;
        m_b1 = w2 >>> 1;
        m_b2 = w2 >>> 2;
        // 2.0 does not fit Q2.16 so the result wraps to 18 bits
        t    = 2 * (1 << FRAC_W) - int'(w2);
        m_a1 = t[SAMPLE_W-1:0];
        t    = (1 << FRAC_W) - 2 * int'(alpha);
        m_a2 = t[SAMPLE_W-1:0];
    endtask

    task automatic model_filter(input logic signed [SAMPLE_W-1:0] x,
                                output logic signed [SAMPLE_W-1:0] y, output logic s);
        logic signed [ACC_W-1:0] acc;
        acc = m_b0 * x + m_b1 * m_x1 + m_b2 * m_x2 + m_a1 * m_y1 - m_a2 * m_y2;
        acc = acc >>> FRAC_W;
        s = (acc > 40'sd131071) || (acc < -40'sd131072);
        if (s) begin
            y = acc[ACC_W-1] ? 18'sh20000 : 18'sh1ffff;
        end else begin
            y = acc[SAMPLE_W-1:0];
        end
        m_x2 = m_x1;
        m_x1 = x;
        m_y2 = m_y1;
        m_y1 = y;
    endtask

    // ------------------------------------------------------
    // Drivers on the falling edge
    // ------------------------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) @(negedge reset);
    endtask

    task automatic send_cc(input logic [MIDI_CMD_W-1:0] cmd, input logic [3:0] ch,
                           input logic [6:0] ctl, input logic [6:0] val);
        @(negedge reset);
        midi_valid = 1'b1;
        midi_cmd   = cmd;
        midi_ch    = ch;
        midi_data0 = ctl;
        midi_data1 = val;
        // Model decodes the same message
        if (cmd == MIDI_CMD_CC && ch == 4'd0 && ctl == 7'd21) m_omega0 = int'(val) * 256;
        if (cmd == MIDI_CMD_CC && ch == 4'd0 && ctl == 7'd22) m_inv_2q = int'(val) * 512;
        model_coefs();
        @(negedge reset);
        midi_valid = 1'b0;
    endtask

    task automatic run_sample(input string name, input logic signed [SAMPLE_W-1:0] x,
                              input logic bp);
        logic signed [SAMPLE_W-1:0] exp_y;
        logic exp_s;
        logic done;
        logic [31:0] r;
        model_filter(x, exp_y, exp_s);
        sat_seen += exp_s;
        @(negedge reset);
        sample_in_valid = 1'b1;
        sample_in       = x;
        while (!sample_in_ready) @(negedge reset);
        @(negedge reset);
        sample_in_valid = 1'b0;
        sent++;
        done = 1'b0;
        while (!done) begin
            // No new input until the output is taken
            check({name, " busy ready"}, 0, int'(sample_in_ready));
            if (bp) begin
                r = lcg_next();
                sample_out_ready = r[20];
            end else begin
                sample_out_ready = 1'b1;
            end
            if (sample_out_valid && sample_out_ready) begin
                check({name, " sample"}, int'(exp_y), int'(sample_out));
                check({name, " overflow"}, int'(exp_s), int'(err_overflow));
                done = 1'b1;
            end
            @(negedge reset);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // ------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------
    initial begin
        logic [31:0] r;
        int d;
        lcg_state = 32'd20670;
        cycles = 0;
        errors = 0;
        checks = 0;
        tests = 0;
        test_errors = 0;
        sent = 0;
        xfers = 0;
        sat_seen = 0;
        clk = 1'b1;
        midi_valid = 1'b0;
        midi_cmd = '0;
        midi_ch = '0;
        midi_data0 = '0;
        midi_data1 = '0;
        sample_in_valid = 1'b0;
        sample_in = '0;
        sample_out_ready = 1'b0;
        m_omega0 = OMEGA0_RESET;
        m_inv_2q = INV_2Q_RESET;
        m_x1 = '0;
        m_x2 = '0;
        m_y1 = '0;
        m_y2 = '0;
        model_coefs();
        repeat (4) @(negedge reset);
        clk = 1'b0;
        wait_cycles(12);

        check("reset_defaults out_valid", 0, int'(sample_out_valid));
        check("reset_defaults overflow", 0, int'(err_overflow));
        for (int i = 0; i < 40; i++) run_sample("reset_defaults", rand_sample(), 1'b0);
        end_test("reset_defaults");

        r = lcg_next();
        send_cc(MIDI_CMD_CC, 4'd0, 7'd21, r[22:16]);
        wait_cycles(12);
        for (int i = 0; i < 40; i++) run_sample("cutoff_change", rand_sample(), 1'b0);
        end_test("cutoff_change");

        r = lcg_next();
        send_cc(MIDI_CMD_CC, 4'd0, 7'd22, r[22:16]);
        // Wrong channel, wrong controller, wrong command
        send_cc(MIDI_CMD_CC, 4'd5, 7'd21, 7'd99);
        send_cc(MIDI_CMD_CC, 4'd0, 7'd30, 7'd99);
        send_cc(3'd1, 4'd0, 7'd22, 7'd1);
        wait_cycles(12);
        for (int i = 0; i < 40; i++) run_sample("resonance_change", rand_sample(), 1'b0);
        end_test("resonance_change");

        d = xfers;
        for (int i = 0; i < 40; i++) run_sample("back_pressure", rand_sample(), 1'b1);
        check("back_pressure count", 40, xfers - d);
        end_test("back_pressure");

        send_cc(MIDI_CMD_CC, 4'd0, 7'd21, 7'd100);
        send_cc(MIDI_CMD_CC, 4'd0, 7'd22, 7'd1);
        wait_cycles(12);
        sat_seen = 0;
        // Full-scale square wave with a period near the resonance
        for (int i = 0; i < 30; i++) begin
            run_sample("saturation", ((i / 8) % 2) ? 18'sh20000 : 18'sh1ffff, 1'b0);
        end
        check("saturation reached", 1, int'(sat_seen > 0));
        end_test("saturation");

        // Same value again keeps the coefficients, but reruns the calculator
        for (int i = 0; i < 30; i++) begin
            r = lcg_next();
            d = r[17:16];
            fork
                run_sample("contention", rand_sample(), 1'b0);
                begin
                    wait_cycles(d);
                    send_cc(MIDI_CMD_CC, 4'd0, 7'd21, 7'd100);
                end
            join
        end
        send_cc(MIDI_CMD_CC, 4'd0, 7'd22, 7'd40);
        wait_cycles(12);
        for (int i = 0; i < 10; i++) run_sample("contention", rand_sample(), 1'b0);
        end_test("contention");

        check("total count", sent, xfers);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: lpf_voice_top.sv
// ----------------------------------------------------------
// Low-pass filter block of one synth voice
// Port reset is the clock, port clk the async high reset
// Latency varies with contention, sample_out_valid marks it
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lpf_voice_top import lpf_pkg::*; #(
    parameter logic [3:0] MIDI_CHANNEL = 4'd0,
    parameter logic [6:0] OMEGA0_CC    = 7'd21,
    parameter logic [6:0] INV_2Q_CC    = 7'd22
) (
    input  wire                         reset,
    input  wire                         clk,
    input  wire                         midi_valid,
    input  wire [MIDI_CMD_W-1:0]        midi_cmd,
    input  wire [3:0]                   midi_ch,
    input  wire [6:0]                   midi_data0,
    input  wire [6:0]                   midi_data1,
    input  wire                         sample_in_valid,
    output logic                        sample_in_ready,
    input  wire signed [SAMPLE_W-1:0]   sample_in,
    output logic                        sample_out_valid,
    input  wire                         sample_out_ready,
    output logic signed [SAMPLE_W-1:0]  sample_out,
    output logic                        err_overflow
);

    logic signed [SAMPLE_W-1:0] omega0;
    logic signed [SAMPLE_W-1:0] inv_2q;
    logic                       stale;
    logic                       calc_start;
    logic                       coef_valid;
    logic [5*SAMPLE_W-1:0]      coefs;

    // Multiplier ports, one per requester
    mult_if iir_mult ();
    mult_if coef_mult ();

    midi_cc_decoder #(
        .MIDI_CHANNEL (MIDI_CHANNEL),
        .OMEGA0_CC    (OMEGA0_CC),
        .INV_2Q_CC    (INV_2Q_CC)
    ) midi_cc_decoder_i (
        .reset      (reset),
        .clk        (clk),
        .midi_valid (midi_valid),
        .midi_cmd   (midi_cmd),
        .midi_ch    (midi_ch),
        .midi_data0 (midi_data0),
        .midi_data1 (midi_data1),
        .calc_start (calc_start),
        .omega0     (omega0),
        .inv_2q     (inv_2q),
        .stale      (stale)
    );

    lpf_coef_calc lpf_coef_calc_i (
        .reset      (reset),
        .clk        (clk),
        .stale      (stale),
        .omega0     (omega0),
        .inv_2q     (inv_2q),
        .calc_start (calc_start),
        .mult       (coef_mult.requester),
        .coef_valid (coef_valid),
        .coefs      (coefs)
    );

    biquad_iir biquad_iir_i (
        .reset            (reset),
        .clk              (clk),
        .coef_valid       (coef_valid),
        .coefs            (coefs),
        .sample_in_valid  (sample_in_valid),
        .sample_in_ready  (sample_in_ready),
        .sample_in        (sample_in),
        .mult             (iir_mult.requester),
        .sample_out_valid (sample_out_valid),
        .sample_out_ready (sample_out_ready),
        .sample_out       (sample_out),
        .err_overflow     (err_overflow)
    );

    shared_mult_arbiter shared_mult_arbiter_i (
        .reset (reset),
        .clk   (clk),
        .iir   (iir_mult.arbiter),
        .coef  (coef_mult.arbiter)
    );

endmodule

`default_nettype wire

// File: midi_cc_decoder.sv
// ----------------------------------------------------------
// Control-change decoder for cutoff and resonance
// Messages arrive decoded, one per cycle, no back-pressure
// Stale is set at reset so coefficients follow at once
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module midi_cc_decoder import lpf_pkg::*; #(
    parameter logic [3:0] MIDI_CHANNEL = 4'd0,
    parameter logic [6:0] OMEGA0_CC    = 7'd21,
    parameter logic [6:0] INV_2Q_CC    = 7'd22
) (
    input  wire                       reset,
    input  wire                       clk,
    input  wire                       midi_valid,
    input  wire [MIDI_CMD_W-1:0]      midi_cmd,
    input  wire [3:0]                 midi_ch,
    input  wire [6:0]                 midi_data0,
    input  wire [6:0]                 midi_data1,
    input  wire                       calc_start,
    output logic signed [SAMPLE_W-1:0] omega0,
    output logic signed [SAMPLE_W-1:0] inv_2q,
    output logic                      stale
);

    logic cc_hit;
    logic omega0_hit;
    logic inv_2q_hit;

    // CC on our channel
    assign cc_hit     = midi_valid && (midi_cmd == MIDI_CMD_CC) && (midi_ch == MIDI_CHANNEL);
    assign omega0_hit = cc_hit && (midi_data0 == OMEGA0_CC);
    assign inv_2q_hit = cc_hit && (midi_data0 == INV_2Q_CC);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            omega0 <= OMEGA0_RESET;
            inv_2q <= INV_2Q_RESET;
            stale  <= 1'b1;
        end else begin
            // 7-bit value lands just below the integer bits
            if (omega0_hit) begin
                omega0 <= {3'b000, midi_data1, 8'h00};
            end
            if (inv_2q_hit) begin
                inv_2q <= {2'b00, midi_data1, 9'h000};
            end
            // A change in the start cycle wins, so another pass follows
            if (omega0_hit || inv_2q_hit) begin
                stale <= 1'b1;
            end else if (calc_start) begin
                stale <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: mult_if.sv
// ----------------------------------------------------------
// One requester's port on the shared 18x18 multiplier
// Operands taken when req and gnt are both high
// Product returns with p_valid two cycles later, in order
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface mult_if import lpf_pkg::*; ();

    // Requester side
    logic                       req;
    logic signed [SAMPLE_W-1:0] a;
    logic signed [SAMPLE_W-1:0] b;

    // Arbiter side
    logic                       gnt;
    logic                       p_valid;
    logic signed [PROD_W-1:0]   p;

    modport requester (output req, a, b, input gnt, p_valid, p);
    modport arbiter   (input req, a, b, output gnt, p_valid, p);

endinterface

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the biquad voice testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module lpf_tb -o lpf_sim \
    || exit 1
out=$(./obj_dir/lpf_sim)
echo "$out"
echo "$out" | grep -qx "All tests passed" && exit 0 || exit 1

// File: shared_mult_arbiter.sv
// ----------------------------------------------------------
// Round-robin arbiter and two-stage 18x18 signed multiplier
// Grant is combinational, tie goes to the last loser
// Owner tag rides with each stage to steer p_valid
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module shared_mult_arbiter import lpf_pkg::*; (
    input  wire     reset,
    input  wire     clk,
    mult_if.arbiter iir,
    mult_if.arbiter coef
);

    // Requester that wins the next tie
    logic                       prio;
    logic                       s1_valid;
    logic                       s1_owner;
    logic                       s2_valid;
    logic                       s2_owner;
    logic signed [SAMPLE_W-1:0] s1_a;
    logic signed [SAMPLE_W-1:0] s1_b;
    logic signed [PROD_W-1:0]   s2_p;

    assign iir.gnt  = iir.req && (!coef.req || (prio == REQ_IIR));
    assign coef.gnt = coef.req && (!iir.req || (prio == REQ_COEF));

    // ------------------------------------------------------
    // Priority and pipeline tags
    // ------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            prio     <= REQ_IIR;
            s1_valid <= 1'b0;
            s1_owner <= REQ_IIR;
            s2_valid <= 1'b0;
            s2_owner <= REQ_IIR;
        end else begin
            if (iir.req && coef.req) begin
                prio <= iir.gnt ? REQ_COEF : REQ_IIR;
            end
            s1_valid <= iir.gnt || coef.gnt;
            s1_owner <= coef.gnt ? REQ_COEF : REQ_IIR;
            s2_valid <= s1_valid;
            s2_owner <= s1_owner;
        end
    end

    // Operand capture then product
    always_ff @(posedge reset) begin
        s1_a <= coef.gnt ? coef.a : iir.a;
        s1_b <= coef.gnt ? coef.b : iir.b;
        s2_p <= s1_a * s1_b;
    end

    // Product bus is shared, valid goes to the owner only
    assign iir.p_valid  = s2_valid && (s2_owner == REQ_IIR);
    assign coef.p_valid = s2_valid && (s2_owner == REQ_COEF);
    assign iir.p        = s2_p;
    assign coef.p       = s2_p;

endmodule

`default_nettype wire

// File: vlog.f
lpf_pkg.sv
mult_if.sv
midi_cc_decoder.sv
lpf_coef_calc.sv
biquad_iir.sv
shared_mult_arbiter.sv
lpf_voice_top.sv
lpf_properties.sv
lpf_tb.sv
